// File: src/cpuPkg.sv
package cpuPkg;

	////////////////////////////////////////
	// Basic types
	////////////////////////////////////////

	// One data word. Accumulators, immediates and data RAM all share this width.
	typedef logic [7:0] dataT;

	// Operation codes for the fourteen instructions.
	typedef enum logic [3:0] {
		OpNop   = 4'h0,
		OpLdi   = 4'h1,
		OpAddi  = 4'h2,
		OpSubi  = 4'h3,
		OpAndi  = 4'h4,
		OpOri   = 4'h5,
		OpXori  = 4'h6,
		OpAdd   = 4'h7,
		OpSub   = 4'h8,
		OpLoad  = 4'h9,
		OpStore = 4'hA,
		OpBeqz  = 4'hB,
		OpJmp   = 4'hC,
		OpHalt  = 4'hD
	} opcodeT;

	// Selects one of the two accumulators.
	typedef enum logic {
		AccA = 1'b0,
		AccB = 1'b1
	} accSelT;

	////////////////////////////////////////
	// Instruction word
	////////////////////////////////////////

	// ALU view of the word. The low byte is an immediate operand.
	typedef struct packed {
		opcodeT     opcode;
		accSelT     acc;
		logic [2:0] reserved;
		dataT       imm;
	} immFormT;

	// Memory and branch view. The low byte is a data or instruction address.
	typedef struct packed {
		opcodeT     opcode;
		accSelT     acc;
		logic [2:0] reserved;
		dataT       addr;
	} addrFormT;

	// The same 16 bits, decoded one way or the other depending on the opcode.
	typedef union packed {
		immFormT  immForm;
		addrFormT addrForm;
	} instrT;

	// One word written into instruction memory before the program runs.
	typedef struct packed {
		instrT      instr;
		logic [7:0] addr;
	} loadReqT;

	////////////////////////////////////////
	// Pipeline register contents
	////////////////////////////////////////

	// IF/ID register.
	typedef struct packed {
		logic       valid;
		instrT      instr;
		logic [7:0] pc;
	} fetchOutT;

	// ID/EX register. The operands are already read from the accumulators.
	typedef struct packed {
		logic   valid;
		opcodeT opcode;
		accSelT dest;
		logic   writeAcc;
		dataT   opA;
		dataT   opB;
		dataT   immAddr;
		logic   useImm;
		logic   halt;
	} decodeOutT;

	// EX/MEM register.
	typedef struct packed {
		logic   valid;
		dataT   result;
		accSelT dest;
		logic   writeAcc;
		logic   store;
		logic   load;
		dataT   addr;
		dataT   storeData;
		logic   halt;
	} execOutT;

	// MEM/WB register, which is also what the commit port shows.
	typedef struct packed {
		logic   valid;
		logic   isStore;
		accSelT dest;
		logic   writeAcc;
		dataT   addr;
		dataT   value;
	} commitT;

endpackage

// File: src/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
	parameter int ImemDepth = 64
) (
	input  logic     clk,
	input  logic     rstN,
	input  logic     run,
	input  loadReqT  loadReq,
	input  logic     loadValid,
	input  logic     stall,
	input  logic     redirectValid,
	input  dataT     redirectPc,
	input  logic     haltSeen,
	output logic     loadReady,
	output fetchOutT fetchOut
);

	localparam int ImemAw = $clog2(ImemDepth);

	// Program storage, written only through the load port.
	instrT imem [ImemDepth];

	// Set by the first high level of run and held until reset.
	logic runSeen;
	dataT pc;

	logic [ImemAw-1:0] fetchIdx;
	logic [ImemAw-1:0] loadIdx;

	// Both addresses wrap at the memory depth.
	assign fetchIdx = ImemAw'(pc % ImemDepth);
	assign loadIdx = ImemAw'(loadReq.addr % ImemDepth);

	// Loading is only possible before the program has been started.
	assign loadReady = !runSeen;

	////////////////////////////////////////
	// Program load
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (loadValid && loadReady) begin
			imem[loadIdx] <= loadReq.instr;
		end
	end

	////////////////////////////////////////
	// PC and IF/ID register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			runSeen <= 1'b0;
			pc <= '0;
			fetchOut <= '0;
		end else begin
			if (run) begin
				runSeen <= 1'b1;
			end
			// A taken branch in execute overrides everything else.
			// The word now in IF/ID is younger than the branch and is dropped.
			if (redirectValid) begin
				pc <= redirectPc;
				fetchOut.valid <= 1'b0;
			end else if (stall) begin
				// Decode is waiting on a writer, so PC and IF/ID keep their values.
				pc <= pc;
			end else if (runSeen && !haltSeen) begin
				fetchOut <= '{valid: 1'b1, instr: imem[fetchIdx], pc: pc};
				pc <= pc + 8'd1;
			end else begin
				// Not started yet, or a HALT has been decoded.
				fetchOut.valid <= 1'b0;
			end
		end
	end

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  fetchOutT  fetchOut,
	input  logic      flush,
	input  execOutT   execOut,
	input  commitT    commit,
	output logic      stall,
	output logic      haltSeen,
	output decodeOutT decodeOut
);

	// The two architectural accumulators.
	dataT accA;
	dataT accB;

	opcodeT opcode;
	accSelT srcAcc;
	dataT lowByte;
	dataT ownAcc;
	logic readsBoth;
	logic readsOwn;
	logic isImmOp;
	logic writesAcc;
	logic needA;
	logic needB;
	logic aBusy;
	logic bBusy;
	logic isHalt;
	logic haltReg;
	decodeOutT nextOut;

	// True when one in-flight record will still write the given accumulator.
	function automatic logic pendingWrite(
		input logic   valid,
		input logic   writeAcc,
		input accSelT dest,
		input accSelT acc
	);
		return valid && writeAcc && (dest == acc);
	endfunction

	////////////////////////////////////////
	// Instruction decode
	////////////////////////////////////////

	// The opcode sits in the same place in both views of the word.
	assign opcode = fetchOut.instr.immForm.opcode;

	// The accumulator select and the low byte also share their place in both views.
	// Memory and branch ops treat the low byte as an address, ALU ops as an immediate.
	assign srcAcc = fetchOut.instr.immForm.acc;
	assign lowByte = fetchOut.instr.immForm.imm;

	// Which accumulators the instruction reads.
	assign readsBoth = opcode inside {OpAdd, OpSub};
	assign readsOwn = opcode inside {OpAddi, OpSubi, OpAndi, OpOri, OpXori, OpBeqz, OpStore};
	assign isImmOp = opcode inside {OpLdi, OpAddi, OpSubi, OpAndi, OpOri, OpXori};
	assign writesAcc = isImmOp || readsBoth || (opcode == OpLoad);

	assign needA = readsBoth || (readsOwn && (srcAcc == AccA));
	assign needB = readsBoth || (readsOwn && (srcAcc == AccB));

	////////////////////////////////////////
	// Interlock
	////////////////////////////////////////

	// Without forwarding, any writer in ID/EX, EX/MEM or MEM/WB blocks the read.
	// The accumulator is only updated as the writer leaves MEM/WB.
	always_comb begin
		aBusy = pendingWrite(decodeOut.valid, decodeOut.writeAcc, decodeOut.dest, AccA)
			|| pendingWrite(execOut.valid, execOut.writeAcc, execOut.dest, AccA)
			|| pendingWrite(commit.valid, commit.writeAcc, commit.dest, AccA);
		bBusy = pendingWrite(decodeOut.valid, decodeOut.writeAcc, decodeOut.dest, AccB)
			|| pendingWrite(execOut.valid, execOut.writeAcc, execOut.dest, AccB)
			|| pendingWrite(commit.valid, commit.writeAcc, commit.dest, AccB);
	end

	assign stall = fetchOut.valid && ((needA && aBusy) || (needB && bBusy));

	// Fetch must stop as soon as a HALT is seen in IF/ID, and stay stopped after it issues.
	assign isHalt = fetchOut.valid && (opcode == OpHalt);
	assign haltSeen = haltReg || isHalt;

	////////////////////////////////////////
	// Operand read
	////////////////////////////////////////

	assign ownAcc = (srcAcc == AccA) ? accA : accB;

	always_comb begin
		nextOut.valid = fetchOut.valid;
		nextOut.opcode = opcode;
		nextOut.dest = srcAcc;
		nextOut.writeAcc = writesAcc;
		// ADD and SUB always compute A op B; everything else uses its own accumulator.
		nextOut.opA = readsBoth ? accA : ownAcc;
		nextOut.opB = accB;
		nextOut.immAddr = lowByte;
		nextOut.useImm = isImmOp;
		nextOut.halt = (opcode == OpHalt);
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			accA <= '0;
			accB <= '0;
			haltReg <= 1'b0;
			decodeOut <= '0;
		end else begin
			// Write-back from the commit record.
			if (commit.valid && commit.writeAcc) begin
				if (commit.dest == AccA) begin
					accA <= commit.value;
				end else begin
					accB <= commit.value;
				end
			end
			// A stall or a flush sends a bubble into ID/EX.
			if (flush || stall) begin
				decodeOut <= '0;
			end else begin
				decodeOut <= nextOut;
			end
			// HALT counts only once it has really issued.
			if (isHalt && !stall && !flush) begin
				haltReg <= 1'b1;
			end
		end
	end

endmodule

// File: src/executeStage.sv
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
	input  logic      clk,
	input  logic      rstN,
	input  decodeOutT decodeOut,
	output logic      redirectValid,
	output dataT      redirectPc,
	output logic      flush,
	output execOutT   execOut
);

	dataT operandB;
	dataT aluResult;
	logic taken;
	logic isStore;
	logic isLoad;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	// Immediate forms replace the second accumulator with the low byte.
	assign operandB = decodeOut.useImm ? decodeOut.immAddr : decodeOut.opB;

	// All arithmetic wraps at 8 bits.
	always_comb begin
		case (decodeOut.opcode)
			OpLdi: aluResult = operandB;
			OpAddi, OpAdd: aluResult = decodeOut.opA + operandB;
			OpSubi, OpSub: aluResult = decodeOut.opA - operandB;
			OpAndi: aluResult = decodeOut.opA & operandB;
			OpOri: aluResult = decodeOut.opA | operandB;
			OpXori: aluResult = decodeOut.opA ^ operandB;
			default: aluResult = '0;
		endcase
	end

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////

	// BEQZ tests the accumulator it names, which decode placed in opA.
	assign taken = decodeOut.valid
		&& ((decodeOut.opcode == OpJmp)
		|| ((decodeOut.opcode == OpBeqz) && (decodeOut.opA == '0)));

	// The redirect takes effect on the same edge that moves the branch into EX/MEM.
	// At that edge IF/ID and ID/EX both get cleared, which drops the two younger ones.
	assign redirectValid = taken;
	assign redirectPc = decodeOut.immAddr;
	assign flush = taken;

	assign isStore = (decodeOut.opcode == OpStore);
	assign isLoad = (decodeOut.opcode == OpLoad);

	////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			execOut <= '0;
		end else begin
			execOut.valid <= decodeOut.valid;
			execOut.result <= aluResult;
			execOut.dest <= decodeOut.dest;
			execOut.writeAcc <= decodeOut.writeAcc;
			execOut.store <= isStore;
			execOut.load <= isLoad;
			execOut.addr <= decodeOut.immAddr;
			// STORE writes the value of its own accumulator.
			execOut.storeData <= decodeOut.opA;
			execOut.halt <= decodeOut.halt;
		end
	end

endmodule

// File: src/memoryStage.sv
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; #(
	parameter int DmemDepth = 16
) (
	input  logic    clk,
	input  logic    rstN,
	input  execOutT execOut,
	output commitT  commit,
	output logic    halted
);

	localparam int DmemAw = $clog2(DmemDepth);

	dataT dmem [DmemDepth];

	logic [DmemAw-1:0] memIdx;
	dataT loadData;
	dataT wbValue;
	logic doCommit;

	// Addresses beyond the depth alias back into the RAM.
	assign memIdx = DmemAw'(execOut.addr % DmemDepth);

	// Asynchronous read, so a LOAD right after a STORE sees the new value.
	assign loadData = dmem[memIdx];

	////////////////////////////////////////
	// Data RAM
	////////////////////////////////////////

	// The RAM starts from zero on every reset so each program sees the same state.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < DmemDepth; i++) begin
				dmem[i] <= '0;
			end
		end else if (execOut.valid && execOut.store) begin
			dmem[memIdx] <= execOut.storeData;
		end
	end

	////////////////////////////////////////
	// MEM/WB commit record
	////////////////////////////////////////

	// Only accumulator and memory writers retire visibly.
	assign doCommit = execOut.valid && (execOut.writeAcc || execOut.store);

	always_comb begin
		if (execOut.load) begin
			wbValue = loadData;
		end else if (execOut.store) begin
			wbValue = execOut.storeData;
		end else begin
			wbValue = execOut.result;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			commit <= '0;
			halted <= 1'b0;
		end else begin
			commit <= '{valid: doCommit, isStore: execOut.store, dest: execOut.dest,
				writeAcc: execOut.writeAcc, addr: execOut.addr, value: wbValue};
			// Sticky; HALT itself leaves commit valid low.
			if (execOut.valid && execOut.halt) begin
				halted <= 1'b1;
			end
		end
	end

endmodule

// File: src/accPipeline.sv
`timescale 1ns/1ps

module accPipeline import cpuPkg::*; #(
	parameter int ImemDepth = 64,
	parameter int DmemDepth = 16
) (
	input  logic    clk,
	input  logic    rstN,
	input  loadReqT loadReq,
	input  logic    loadValid,
	output logic    loadReady,
	input  logic    run,
	output commitT  commit,
	output logic    halted
);

	////////////////////////////////////////
	// Stage-to-stage signals
	////////////////////////////////////////

	fetchOutT fetchOut;
	decodeOutT decodeOut;
	execOutT execOut;

	// Feedback from decode and execute towards fetch.
	logic stall;
	logic haltSeen;
	logic redirectValid;
	dataT redirectPc;
	logic flush;

	// Fetch with its IF/ID register.
	fetchStage #(
		.ImemDepth(ImemDepth)
	) fetchInst (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.loadReq(loadReq),
		.loadValid(loadValid),
		.stall(stall),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.haltSeen(haltSeen),
		.loadReady(loadReady),
		.fetchOut(fetchOut)
	);

	// Decode reads the commit record both for write-back and for the interlock.
	decodeStage decodeInst (
		.clk(clk),
		.rstN(rstN),
		.fetchOut(fetchOut),
		.flush(flush),
		.execOut(execOut),
		.commit(commit),
		.stall(stall),
		.haltSeen(haltSeen),
		.decodeOut(decodeOut)
	);

	executeStage executeInst (
		.clk(clk),
		.rstN(rstN),
		.decodeOut(decodeOut),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.flush(flush),
		.execOut(execOut)
	);

	memoryStage #(
		.DmemDepth(DmemDepth)
	) memoryInst (
		.clk(clk),
		.rstN(rstN),
		.execOut(execOut),
		.commit(commit),
		.halted(halted)
	);

endmodule

// File: verification/accPipeline_properties.sv
`timescale 1ns/1ps

module accPipelineProperties import cpuPkg::*; (
	input logic   clk,
	input logic   rstN,
	input logic   run,
	input logic   loadReady,
	input commitT commit,
	input logic   halted
);

	////////////////////////////////////////
	// Control behaviour
	////////////////////////////////////////

	// Once set, halted only clears through reset.
	haltedSticky: assert property (@(posedge clk) disable iff (!rstN) !$fell(halted))
		else $error("halted fell while reset was inactive");

	// The load port closes for good once run has been seen.
	loadClosedByRun: assert property (@(posedge clk) disable iff (!rstN) run |=> !loadReady)
		else $error("loadReady was high after run");

	loadStaysClosed: assert property (@(posedge clk) disable iff (!rstN)
		!loadReady |=> !loadReady)
		else $error("loadReady rose again without reset");

	// Everything older than HALT has retired by the time halted rises.
	noCommitWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !commit.valid)
		else $error("commit valid while halted");

	noUnknownOutputs: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown({loadReady, halted, commit}))
		else $error("unknown value on a top-level output");

endmodule

bind accPipeline accPipelineProperties propertiesInst (
	.clk(clk),
	.rstN(rstN),
	.run(run),
	.loadReady(loadReady),
	.commit(commit),
	.halted(halted)
);

// File: verification/accPipelineTb.sv
`timescale 1ns/1ps

module accPipelineTb import cpuPkg::*; ();

	localparam int NumPrograms = 4;
	localparam int CyclesPerInstr = 10;
	localparam int CyclesPerProgram = 50;
	localparam logic [31:0] LfsrSeed = 32'hb42f4262;

	// One table row is one program word with the commit it should produce.
	typedef struct packed {
		logic [3:0] prog;
		instrT      instr;
		logic       hasCommit;
		logic       isStore;
		accSelT     dest;
		dataT       addr;
		dataT       value;
	} rowT;

	logic clk;
	logic rstN;
	loadReqT loadReq;
	logic loadValid;
	logic loadReady;
	logic run;
	commitT commit;
	logic halted;

	rowT stimRows[$];
	logic [31:0] lfsrState;
	int cycleCount;
	int cycleLimit;

	accPipeline #(
		.ImemDepth(64),
		.DmemDepth(16)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.loadReq(loadReq),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.run(run),
		.commit(commit),
		.halted(halted)
	);

	////////////////////////////////////////
	// Clock and watchdog
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// The limit is set once the table is built, so zero means not armed yet.
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge clk);
			cycleCount++;
			if (cycleLimit > 0 && cycleCount > cycleLimit) begin
				$display("The run timed out after %0d clock cycles", cycleCount);
				$display("Some tests failed");
				$fatal(1, "Simulation stopped by the watchdog");
			end
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic abortRun();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// Galois form of a 32-bit maximal-length LFSR, shifting right.
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'hA3000000;
		end
		return state >> 1;
	endfunction

	function automatic logic randomBit();
		logic b;
		b = lfsrState[0];
		lfsrState = lfsrStep(lfsrState);
		return b;
	endfunction

	// The commit record names the instruction's own accumulator and low byte.
	task automatic addRow(
		input int     prog,
		input opcodeT op,
		input accSelT acc,
		input dataT   low,
		input logic   hasCommit,
		input dataT   value
	);
		rowT row;
		row.prog = 4'(prog);
		row.instr = {op, acc, 3'b000, low};
		row.hasCommit = hasCommit;
		row.isStore = (op == OpStore);
		row.dest = acc;
		row.addr = low;
		row.value = value;
		stimRows.push_back(row);
	endtask

	////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////

	task automatic buildTable();
		// Program 0: immediate ALU ops with 8-bit wraparound. The word after HALT must never run.
		addRow(0, OpLdi, AccA, 8'h5A, 1'b1, 8'h5A);
		addRow(0, OpAddi, AccA, 8'hC0, 1'b1, 8'h1A);
		addRow(0, OpSubi, AccA, 8'h20, 1'b1, 8'hFA);
		addRow(0, OpAndi, AccA, 8'h0F, 1'b1, 8'h0A);
		addRow(0, OpOri, AccA, 8'h30, 1'b1, 8'h3A);
		addRow(0, OpXori, AccA, 8'hFF, 1'b1, 8'hC5);
		addRow(0, OpLdi, AccB, 8'h80, 1'b1, 8'h80);
		addRow(0, OpAddi, AccB, 8'h80, 1'b1, 8'h00);
		addRow(0, OpNop, AccA, 8'h00, 1'b0, 8'h00);
		addRow(0, OpHalt, AccA, 8'h00, 1'b0, 8'h00);
		addRow(0, OpLdi, AccA, 8'hFF, 1'b0, 8'h00);
		// Program 1: every word depends on the one before, so the interlock is exercised.
		addRow(1, OpLdi, AccA, 8'h25, 1'b1, 8'h25);
		addRow(1, OpLdi, AccB, 8'h13, 1'b1, 8'h13);
		addRow(1, OpAdd, AccA, 8'h00, 1'b1, 8'h38);
		addRow(1, OpSub, AccB, 8'h00, 1'b1, 8'h25);
		addRow(1, OpAdd, AccB, 8'h00, 1'b1, 8'h5D);
		addRow(1, OpSub, AccA, 8'h00, 1'b1, 8'hDB);
		addRow(1, OpAddi, AccB, 8'h01, 1'b1, 8'h5E);
		addRow(1, OpHalt, AccA, 8'h00, 1'b0, 8'h00);
		// Program 2: store and load. Addresses 0x15 and 0x25 both alias to word 5.
		addRow(2, OpLdi, AccA, 8'h77, 1'b1, 8'h77);
		addRow(2, OpStore, AccA, 8'h03, 1'b1, 8'h77);
		addRow(2, OpLdi, AccB, 8'h99, 1'b1, 8'h99);
		addRow(2, OpStore, AccB, 8'h15, 1'b1, 8'h99);
		addRow(2, OpLoad, AccB, 8'h03, 1'b1, 8'h77);
		addRow(2, OpLoad, AccA, 8'h25, 1'b1, 8'h99);
		addRow(2, OpSub, AccA, 8'h00, 1'b1, 8'h22);
		addRow(2, OpLoad, AccB, 8'h0E, 1'b1, 8'h00);
		addRow(2, OpHalt, AccA, 8'h00, 1'b0, 8'h00);
		// Program 3: taken BEQZ, not-taken BEQZ and JMP. Skipped words never commit.
		addRow(3, OpLdi, AccA, 8'h00, 1'b1, 8'h00);
		addRow(3, OpBeqz, AccA, 8'h04, 1'b0, 8'h00);
		addRow(3, OpLdi, AccB, 8'hEE, 1'b0, 8'h00);
		addRow(3, OpLdi, AccA, 8'hEE, 1'b0, 8'h00);
		addRow(3, OpLdi, AccB, 8'h01, 1'b1, 8'h01);
		addRow(3, OpBeqz, AccB, 8'h08, 1'b0, 8'h00);
		addRow(3, OpAddi, AccB, 8'h02, 1'b1, 8'h03);
		addRow(3, OpJmp, AccA, 8'h0A, 1'b0, 8'h00);
		addRow(3, OpLdi, AccA, 8'h55, 1'b0, 8'h00);
		addRow(3, OpLdi, AccB, 8'h55, 1'b0, 8'h00);
		addRow(3, OpAddi, AccA, 8'h07, 1'b1, 8'h07);
		addRow(3, OpHalt, AccA, 8'h00, 1'b0, 8'h00);
		addRow(3, OpLdi, AccA, 8'hFF, 1'b0, 8'h00);
	endtask

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic compareField(input string name, input dataT expected, input dataT actual);
		assert (actual == expected) else begin
			$display("CHECK FAILED at time %0t: %s expected 0x%02h, got 0x%02h",
				$time, name, expected, actual);
			abortRun();
		end
	endtask

	// The address only means something for LOAD and STORE.
	task automatic checkCommit(input rowT row);
		opcodeT op;
		op = row.instr.immForm.opcode;
		compareField("commit.isStore", 8'(row.isStore), 8'(commit.isStore));
		compareField("commit.writeAcc", 8'(!row.isStore), 8'(commit.writeAcc));
		compareField("commit.dest", 8'(row.dest), 8'(commit.dest));
		if (op == OpLoad || op == OpStore) begin
			compareField("commit.addr", row.addr, commit.addr);
		end
		compareField("commit.value", row.value, commit.value);
	endtask

	////////////////////////////////////////
	// Reset, load and run
	////////////////////////////////////////

	task automatic resetDut();
		@(posedge clk);
		rstN <= 1'b0;
		run <= 1'b0;
		loadValid <= 1'b0;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		assert (loadReady && !halted && !commit.valid) else begin
			$display("The DUT did not come out of reset idle and ready to load");
			abortRun();
		end
		@(posedge clk);
	endtask

	task automatic loadProgram(input int prog);
		int word;
		int gapPos;
		logic hi;
		logic lo;
		word = 0;
		gapPos = 0;
		foreach (stimRows[i]) begin
			if (stimRows[i].prog == 4'(prog)) begin
				// Each group of three words gets one idle cycle at a random place.
				if (word % 3 == 0) begin
					hi = randomBit();
					lo = randomBit();
					gapPos = {hi, lo} % 3;
				end
				if (word % 3 == gapPos) begin
					loadValid <= 1'b0;
					@(posedge clk);
				end
				loadValid <= 1'b1;
				loadReq <= '{instr: stimRows[i].instr, addr: 8'(word)};
				// The word is taken at the first edge with ready high.
				@(negedge clk);
				while (!loadReady) begin
					@(negedge clk);
				end
				@(posedge clk);
				word++;
			end
		end
		loadValid <= 1'b0;
	endtask

	task automatic runProgram(input int prog);
		rowT expected[$];
		rowT row;
		logic done;
		foreach (stimRows[i]) begin
			if (stimRows[i].prog == 4'(prog) && stimRows[i].hasCommit) begin
				expected.push_back(stimRows[i]);
			end
		end
		run <= 1'b1;
		done = 1'b0;
		// Commits are compared in program order at the falling edge, where they are stable.
		while (!done) begin
			@(negedge clk);
			if (commit.valid) begin
				assert (expected.size() > 0) else begin
					$display("Program %0d made a commit after all expected ones", prog);
					abortRun();
				end
				row = expected.pop_front();
				checkCommit(row);
			end
			if (halted) begin
				done = 1'b1;
			end
		end
		assert (expected.size() == 0) else begin
			$display("Program %0d halted with %0d expected commits missing",
				prog, expected.size());
			abortRun();
		end
		// Nothing may retire once halted is up.
		repeat (5) begin
			@(negedge clk);
			assert (halted && !commit.valid) else begin
				$display("Program %0d committed or dropped halted after halting", prog);
				abortRun();
			end
		end
	endtask

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		loadValid = 1'b0;
		loadReq = '0;
		lfsrState = LfsrSeed;
		buildTable();
		cycleLimit = stimRows.size() * CyclesPerInstr + NumPrograms * CyclesPerProgram;
		for (int prog = 0; prog < NumPrograms; prog++) begin
			resetDut();
			loadProgram(prog);
			runProgram(prog);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// File: tb.f
src/cpuPkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/accPipeline.sv
verification/accPipeline_properties.sv
verification/accPipelineTb.sv

// File: Makefile
TOP = accPipelineTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
